/* hw/sfifo_defines.svh */
// Size parameters of the shared-buffer multi-queue, included by the package, the RTL and the testbench
`ifndef SFIFO_DEFINES_SVH
`define SFIFO_DEFINES_SVH

// Number of logical FIFOs sharing the RAM
`define SFIFO_NUM_FIFOS 4

// Total words in the shared RAM, split into static regions
`define SFIFO_DEPTH 32

// Payload width of one word
`define SFIFO_DATA_WIDTH 16

`endif

/* hw/sfifo_pkg.sv */
// Shared types of the multi-queue, referenced by scoped name from the RTL and the testbench
`include "sfifo_defines.svh"

package sfifo_pkg;

  // Meaningful widths
  typedef logic [$clog2(`SFIFO_DEPTH)-1:0] addr_t;
  typedef logic [$clog2(`SFIFO_DEPTH+1)-1:0] count_t;
  typedef logic [`SFIFO_DATA_WIDTH-1:0] data_t;
  typedef logic [$clog2(`SFIFO_NUM_FIFOS)-1:0] fifo_id_t;

  // Static region of one FIFO, bound is the last address and inclusive
  typedef struct packed {
    addr_t base;
    addr_t bound;
  } region_cfg_t;

  typedef struct packed {
    logic     valid;
    fifo_id_t id;
    data_t    data;
  } push_req_t;

  typedef struct packed {
    logic     valid;
    fifo_id_t id;
  } pop_req_t;

  // Write pointer state handed from the push side to one pointer manager
  typedef struct packed {
    logic  advance;
    addr_t tail;
    addr_t tail_next;
  } tail_upd_t;

endpackage

/* hw/sfifo_ram.sv */
// Shared storage for all FIFO regions with one write port and a registered read port
`timescale 1ns/1ps
`include "sfifo_defines.svh"

module sfifo_ram (
  input  logic             clk,
  input  logic             we,
  input  sfifo_pkg::addr_t waddr,
  input  sfifo_pkg::data_t wdata,
  input  logic             re,
  input  sfifo_pkg::addr_t raddr,
  output sfifo_pkg::data_t rdata
);

  sfifo_pkg::data_t mem [`SFIFO_DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read data appears one cycle after re and holds until the next read
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

/* hw/sfifo_push_ctrl.sv */
// Push side of the multi-queue: tail pointers per FIFO, RAM write and overflow reporting
`timescale 1ns/1ps
`include "sfifo_defines.svh"

module sfifo_push_ctrl (
  input  logic                                            clk,
  input  logic                                            arst_n,
  input  sfifo_pkg::region_cfg_t [`SFIFO_NUM_FIFOS-1:0] cfg,
  input  sfifo_pkg::push_req_t                           push,
  input  logic                   [`SFIFO_NUM_FIFOS-1:0] push_full,
  output sfifo_pkg::tail_upd_t   [`SFIFO_NUM_FIFOS-1:0] tail_upd,
  output logic                                            we,
  output sfifo_pkg::addr_t                               waddr,
  output sfifo_pkg::data_t                               wdata,
  output logic                                            push_overflow
);

  sfifo_pkg::addr_t [`SFIFO_NUM_FIFOS-1:0] tail_q;
  sfifo_pkg::addr_t [`SFIFO_NUM_FIFOS-1:0] tail_next;
  logic [`SFIFO_NUM_FIFOS-1:0] advance;
  logic accept;
  logic drop;

  // A push is taken only if its FIFO has room
  assign accept = push.valid && !push_full[push.id];
  assign drop   = push.valid && push_full[push.id];

  // Write lands at the current tail in the accepting edge
  assign we    = accept;
  assign waddr = tail_q[push.id];
  assign wdata = push.data;

  for (genvar i = 0; i < `SFIFO_NUM_FIFOS; i++) begin : gen_tail
    assign advance[i]   = accept && (push.id == sfifo_pkg::fifo_id_t'(i));
    assign tail_next[i] = (tail_q[i] == cfg[i].bound) ? cfg[i].base : tail_q[i] + 1'b1;

    assign tail_upd[i].advance   = advance[i];
    assign tail_upd[i].tail      = tail_q[i];
    assign tail_upd[i].tail_next = tail_next[i];

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        tail_q[i] <= cfg[i].base;
      end else if (advance[i]) begin
        tail_q[i] <= tail_next[i];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      push_overflow <= 1'b0;
    end else begin
      push_overflow <= drop;
    end
  end

  // Push id must address an existing FIFO
  push_id_in_range_a: assert property (@(posedge clk) disable iff (!arst_n)
    push.valid |-> (int'(push.id) < `SFIFO_NUM_FIFOS));

  // Every write stays inside the region of the addressed FIFO
  write_in_region_a: assert property (@(posedge clk) disable iff (!arst_n)
    we |-> (waddr >= cfg[push.id].base) && (waddr <= cfg[push.id].bound));

endmodule

/* hw/sfifo_ptr_mgr.sv */
// Head pointer, full and empty flags and item count of one FIFO, instantiated once per FIFO
`timescale 1ns/1ps

module sfifo_ptr_mgr (
  input  logic                   clk,
  input  logic                   arst_n,
  input  sfifo_pkg::region_cfg_t cfg,
  input  sfifo_pkg::tail_upd_t   tail_upd,
  input  logic                   head_ready,
  output logic                   head_valid,
  output sfifo_pkg::addr_t       head,
  output logic                   push_full,
  output logic                   ram_empty,
  output sfifo_pkg::count_t      ram_items
);

  logic              advance_head;
  logic              advance_tail;
  sfifo_pkg::addr_t  head_next;
  logic              full_next;
  logic              empty_next;
  sfifo_pkg::count_t region_size;
  sfifo_pkg::addr_t  tail_head_diff;
  sfifo_pkg::addr_t  head_tail_diff;

  assign advance_tail = tail_upd.advance;
  assign head_valid   = ~ram_empty;
  assign advance_head = head_ready & head_valid;

  // Bound is inclusive, so the head wraps after reading it
  assign head_next = (head == cfg.bound) ? cfg.base : head + 1'b1;

  assign region_size = sfifo_pkg::count_t'(cfg.bound - cfg.base) + sfifo_pkg::count_t'(1);

  always_comb begin
    full_next  = push_full;
    empty_next = ram_empty;
    if (advance_head && !advance_tail) begin
      // Reading alone can only drain
      full_next  = 1'b0;
      empty_next = (head_next == tail_upd.tail);
    end else if (advance_tail && !advance_head) begin
      // Writing alone can only fill
      full_next  = (tail_upd.tail_next == head);
      empty_next = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head      <= cfg.base;
      push_full <= 1'b0;
      ram_empty <= 1'b1;
    end else begin
      if (advance_head) begin
        head <= head_next;
      end
      push_full <= full_next;
      ram_empty <= empty_next;
    end
  end

  // Items from the pointers; when head is above tail the gap is the free space
  assign tail_head_diff = tail_upd.tail - head;
  assign head_tail_diff = head - tail_upd.tail;

  assign ram_items = push_full ? region_size :
                     (tail_upd.tail >= head) ? sfifo_pkg::count_t'(tail_head_diff) :
                     region_size - sfifo_pkg::count_t'(head_tail_diff);

  // Push side must honour its advance strobe
  tail_moves_on_advance_a: assert property (@(posedge clk) disable iff (!arst_n)
    advance_tail |=> (tail_upd.tail == $past(tail_upd.tail_next)));
  tail_holds_otherwise_a: assert property (@(posedge clk) disable iff (!arst_n)
    !advance_tail |=> $stable(tail_upd.tail));

  empty_no_items_a: assert property (@(posedge clk) disable iff (!arst_n)
    ram_empty |-> (ram_items == '0));

  full_or_empty_ptr_match_a: assert property (@(posedge clk) disable iff (!arst_n)
    (push_full || ram_empty) |-> (head == tail_upd.tail));

  items_incr_a: assert property (@(posedge clk) disable iff (!arst_n)
    (advance_tail && !advance_head) |=> (ram_items == $past(ram_items) + 1'b1));
  items_decr_a: assert property (@(posedge clk) disable iff (!arst_n)
    (advance_head && !advance_tail) |=> (ram_items == $past(ram_items) - 1'b1));

  items_within_size_a: assert property (@(posedge clk) disable iff (!arst_n)
    ram_items <= region_size);

endmodule

/* hw/sfifo_pop_ctrl.sv */
// Pop controller used by the multi-queue top to pick the addressed head, read the RAM and flag underflow
`timescale 1ns/1ps
`include "sfifo_defines.svh"

module sfifo_pop_ctrl (
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  sfifo_pkg::pop_req_t                      pop,
  input  logic             [`SFIFO_NUM_FIFOS-1:0] head_valid,
  input  sfifo_pkg::addr_t [`SFIFO_NUM_FIFOS-1:0] head,
  output logic             [`SFIFO_NUM_FIFOS-1:0] head_ready,
  output logic                                      re,
  output sfifo_pkg::addr_t                         raddr,
  output logic                                      pop_data_valid,
  output logic                                      pop_underflow
);

  logic sel_valid;

  // One-hot strobe to the pointer manager of the addressed FIFO
  for (genvar i = 0; i < `SFIFO_NUM_FIFOS; i++) begin : gen_ready
    assign head_ready[i] = pop.valid && (pop.id == sfifo_pkg::fifo_id_t'(i));
  end

  assign sel_valid = head_valid[pop.id];

  // Read only when the addressed FIFO holds data
  assign re    = pop.valid && sel_valid;
  assign raddr = head[pop.id];

  // Valid lines up with the registered RAM output
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pop_data_valid <= 1'b0;
      pop_underflow  <= 1'b0;
    end else begin
      pop_data_valid <= re;
      pop_underflow  <= pop.valid && !sel_valid;
    end
  end

endmodule

/* hw/sfifo_top.sv */
// Top of the shared-buffer multi-queue, wiring push and pop control, the RAM and pointer managers
`timescale 1ns/1ps
`include "sfifo_defines.svh"

module sfifo_top (
  input  logic                                            clk,
  input  logic                                            arst_n,
  input  sfifo_pkg::region_cfg_t [`SFIFO_NUM_FIFOS-1:0] cfg,
  input  sfifo_pkg::push_req_t                           push,
  input  sfifo_pkg::pop_req_t                            pop,
  output sfifo_pkg::data_t                               pop_data,
  output logic                                            pop_data_valid,
  output logic                                            push_overflow,
  output logic                                            pop_underflow,
  output logic                   [`SFIFO_NUM_FIFOS-1:0] fifo_empty,
  output logic                   [`SFIFO_NUM_FIFOS-1:0] fifo_full,
  output sfifo_pkg::count_t      [`SFIFO_NUM_FIFOS-1:0] fifo_items
);

  sfifo_pkg::tail_upd_t [`SFIFO_NUM_FIFOS-1:0] tail_upd;
  sfifo_pkg::addr_t     [`SFIFO_NUM_FIFOS-1:0] head;
  logic                 [`SFIFO_NUM_FIFOS-1:0] head_valid;
  logic                 [`SFIFO_NUM_FIFOS-1:0] head_ready;
  logic                                         we;
  sfifo_pkg::addr_t                             waddr;
  sfifo_pkg::data_t                             wdata;
  logic                                         re;
  sfifo_pkg::addr_t                             raddr;

  sfifo_push_ctrl sfifo_push_ctrl_inst (
    .clk           (clk),
    .arst_n        (arst_n),
    .cfg           (cfg),
    .push          (push),
    .push_full     (fifo_full),
    .tail_upd      (tail_upd),
    .we            (we),
    .waddr         (waddr),
    .wdata         (wdata),
    .push_overflow (push_overflow)
  );

  sfifo_ram sfifo_ram_inst (
    .clk   (clk),
    .we    (we),
    .waddr (waddr),
    .wdata (wdata),
    .re    (re),
    .raddr (raddr),
    .rdata (pop_data)
  );

  sfifo_pop_ctrl sfifo_pop_ctrl_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .pop            (pop),
    .head_valid     (head_valid),
    .head           (head),
    .head_ready     (head_ready),
    .re             (re),
    .raddr          (raddr),
    .pop_data_valid (pop_data_valid),
    .pop_underflow  (pop_underflow)
  );

  for (genvar i = 0; i < `SFIFO_NUM_FIFOS; i++) begin : gen_ptr_mgr
    sfifo_ptr_mgr sfifo_ptr_mgr_inst (
      .clk        (clk),
      .arst_n     (arst_n),
      .cfg        (cfg[i]),
      .tail_upd   (tail_upd[i]),
      .head_ready (head_ready[i]),
      .head_valid (head_valid[i]),
      .head       (head[i]),
      .push_full  (fifo_full[i]),
      .ram_empty  (fifo_empty[i]),
      .ram_items  (fifo_items[i])
    );
  end

endmodule

/* dv/sfifo_tb.sv */
// Testbench for the multi-queue: runs the operations listed in the input file against the DUT
`timescale 1ns/1ps
`include "sfifo_defines.svh"

module sfifo_tb;

  localparam int POP_TIMEOUT = 20;

  logic                                          clk;
  logic                                          arst_n;
  sfifo_pkg::region_cfg_t [`SFIFO_NUM_FIFOS-1:0] cfg;
  sfifo_pkg::push_req_t                          push;
  sfifo_pkg::pop_req_t                           pop;
  sfifo_pkg::data_t                              pop_data;
  logic                                          pop_data_valid;
  logic                                          push_overflow;
  logic                                          pop_underflow;
  logic                   [`SFIFO_NUM_FIFOS-1:0] fifo_empty;
  logic                   [`SFIFO_NUM_FIFOS-1:0] fifo_full;
  sfifo_pkg::count_t      [`SFIFO_NUM_FIFOS-1:0] fifo_items;

  int          fd;
  int          fields;
  int          id;
  logic [31:0] arg_a;
  logic [31:0] arg_b;
  logic [63:0] op;
  string       line;

  sfifo_top sfifo_top_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .cfg            (cfg),
    .push           (push),
    .pop            (pop),
    .pop_data       (pop_data),
    .pop_data_valid (pop_data_valid),
    .push_overflow  (push_overflow),
    .pop_underflow  (pop_underflow),
    .fifo_empty     (fifo_empty),
    .fifo_full      (fifo_full),
    .fifo_items     (fifo_items)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input sfifo_pkg::data_t actual, input sfifo_pkg::data_t expected,
                            input string what);
    if (actual !== expected) begin
      abort_run($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected));
    end
  endtask

  task automatic check_count(input sfifo_pkg::count_t actual, input sfifo_pkg::count_t expected,
                             input string what);
    if (actual !== expected) begin
      abort_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d", $time, what, actual, expected));
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      abort_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, actual, expected));
    end
  endtask

  // Strobe held for one rising edge, overflow pulse seen at the next falling edge
  task automatic do_push(input int fid, input sfifo_pkg::data_t data, input logic ovf);
    push.valid = 1'b1;
    push.id    = sfifo_pkg::fifo_id_t'(fid);
    push.data  = data;
    @(negedge clk);
    push = '0;
    check_flag(push_overflow, ovf, "push_overflow");
  endtask

  task automatic do_pop(input int fid, input sfifo_pkg::data_t word, input logic unf);
    int waits;
    pop.valid = 1'b1;
    pop.id    = sfifo_pkg::fifo_id_t'(fid);
    @(negedge clk);
    pop = '0;
    check_flag(pop_underflow, unf, "pop_underflow");
    if (unf) begin
      check_flag(pop_data_valid, 1'b0, "pop_data_valid on underflow");
    end else begin
      waits = 1;
      while (!pop_data_valid && waits < POP_TIMEOUT) begin
        @(negedge clk);
        waits++;
      end
      if (!pop_data_valid) begin
        abort_run($sformatf("Timed out after %0d cycles waiting for pop_data_valid", waits));
      end
      check_flag(waits == 1, 1'b1, "pop data one cycle after the strobe");
      check_data(pop_data, word, "pop_data");
    end
  endtask

  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    push   = '0;
    pop    = '0;
    // Four regions of 8 words each
    for (int i = 0; i < `SFIFO_NUM_FIFOS; i++) begin
      cfg[i].base  = sfifo_pkg::addr_t'(8 * i);
      cfg[i].bound = sfifo_pkg::addr_t'(8 * i + 7);
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    for (int i = 0; i < `SFIFO_NUM_FIFOS; i++) begin
      check_flag(fifo_empty[i], 1'b1, "fifo_empty after reset");
      check_flag(fifo_full[i], 1'b0, "fifo_full after reset");
      check_count(fifo_items[i], '0, "fifo_items after reset");
    end
    check_flag(push_overflow, 1'b0, "push_overflow after reset");
    check_flag(pop_underflow, 1'b0, "pop_underflow after reset");
    check_flag(pop_data_valid, 1'b0, "pop_data_valid after reset");

    fd = $fopen("dv/sfifo_input.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file dv/sfifo_input.txt");
    end
    while ($fgets(line, fd) != 0) begin
      op     = '0;
      fields = $sscanf(line, "%s %d %h %h", op, id, arg_a, arg_b);
      // Blank and comment lines carry no operation
      if (fields < 1 || op == "#") begin
        continue;
      end
      if (fields < 3) begin
        abort_run($sformatf("Malformed line in stimulus file: %s", line));
      end
      case (op)
        "push": do_push(id, sfifo_pkg::data_t'(arg_a), arg_b[0]);
        "pop": do_pop(id, sfifo_pkg::data_t'(arg_a), arg_b[0]);
        "count": check_count(fifo_items[id], sfifo_pkg::count_t'(arg_a), "fifo_items");
        "flags": begin
          check_flag(fifo_empty[id], arg_a[0], "fifo_empty");
          check_flag(fifo_full[id], arg_b[0], "fifo_full");
        end
        "idle": repeat (arg_a) @(negedge clk);
        default: abort_run($sformatf("Unknown operation in stimulus file: %s", line));
      endcase
    end
    $fclose(fd);
    $display("TEST PASS");
    $finish;
  end

endmodule

/* dv/sfifo_input.txt */
# op id a b: push id data ovf, pop id word unf, count id items,
# flags id empty full, idle id cycles; id is decimal, a and b are hex
push 0 0a01 0
push 1 1b01 0
push 2 2c01 0
push 0 0a02 0
push 3 3d01 0
count 0 2
pop 3 3d01 0
pop 0 0a01 0
pop 2 2c01 0
pop 1 1b01 0
pop 0 0a02 0
pop 0 0000 1
idle 0 3
push 0 0b01 0
push 0 0b02 0
push 0 0b03 0
push 0 0b04 0
push 0 0b05 0
push 0 0b06 0
push 0 0b07 0
push 0 0b08 0
flags 0 0 1
push 0 dead 1
pop 0 0b01 0
pop 0 0b02 0
pop 0 0b03 0
count 0 5
pop 0 0b04 0
pop 0 0b05 0
pop 0 0b06 0
pop 0 0b07 0
pop 0 0b08 0
flags 0 1 0

/* sim.f */
+incdir+hw
hw/sfifo_pkg.sv
hw/sfifo_ram.sv
hw/sfifo_push_ctrl.sv
hw/sfifo_ptr_mgr.sv
hw/sfifo_pop_ctrl.sv
hw/sfifo_top.sv
dv/sfifo_tb.sv

/* Bender.yml */
package:
  name: sfifo

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/sfifo_pkg.sv
      - hw/sfifo_ram.sv
      - hw/sfifo_push_ctrl.sv
      - hw/sfifo_ptr_mgr.sv
      - hw/sfifo_pop_ctrl.sv
      - hw/sfifo_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/sfifo_tb.sv
